// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pool_engine
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
rtl/pool_pkg.sv
rtl/pool_ctrl.sv
rtl/window_counter.sv
rtl/atom_deserializer.sv
rtl/pool_lanes.sv
rtl/result_serializer.sv
rtl/pool_engine_top.sv
sim/pool_checker.sv
sim/tb_pool_engine.sv

// ==== rtl/atom_deserializer.sv ====
`timescale 1ns/1ps

module atom_deserializer (
	input logic clk,
	input logic rst,
	input logic i_busy,
	input pool_pkg::word_t i_word,
	output pool_pkg::atom_strb_t o_atom
);

	logic [pool_pkg::LANE_IDX_W-1:0] lane_idx;
	pool_pkg::atom_t shift_q;
	logic valid_q;
	logic take;
	logic wrap;

	assign take = i_busy && i_word.valid; // Words outside a command are dropped
	assign wrap = (lane_idx == pool_pkg::LAST_LANE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_idx <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= take && wrap;
			if (!i_busy)
				lane_idx <= '0;
			else if (take)
				lane_idx <= wrap ? '0 : lane_idx + 1'b1;
		end
	end

	// New word enters at the top so lane 0 ends up holding the first word
	always_ff @(posedge clk) begin
		if (take)
			shift_q <= {i_word.data, shift_q[pool_pkg::LANES-1:1]};
	end

	assign o_atom = '{valid: valid_q, first: 1'b0, last: 1'b0, atom: shift_q};

	a_whole_atoms: assert property (
		@(posedge clk) disable iff (rst)
		$fell(i_busy) |-> (lane_idx == '0)
	) else $error("atom_deserializer: command ended with lane index %0d", lane_idx);

endmodule

// ==== rtl/pool_ctrl.sv ====
`timescale 1ns/1ps

module pool_ctrl (
	input logic clk,
	input logic rst,
	input logic i_cmd_valid,
	input pool_pkg::pool_cmd_t i_cmd,
	input logic i_cmd_last,
	input logic i_ser_busy,
	output pool_pkg::pool_cmd_t o_cmd,
	output logic o_busy,
	output logic o_done
);

	pool_pkg::ctrl_state_e state;
	pool_pkg::ctrl_state_e state_d;
	pool_pkg::pool_cmd_t cmd_q;
	logic cmd_accept;

	// A strobe outside idle is dropped
	assign cmd_accept = (state == pool_pkg::ST_IDLE) && i_cmd_valid;

	always_comb begin
		state_d = state;
		case (state)
			pool_pkg::ST_IDLE: begin
				if (cmd_accept)
					state_d = pool_pkg::ST_BUSY;
			end
			pool_pkg::ST_BUSY: begin
				if (i_cmd_last) // Final atom of the final window seen
					state_d = pool_pkg::ST_DRAIN;
			end
			pool_pkg::ST_DRAIN: begin
				// Serializer drops busy while it sends the last result word
				if (!i_ser_busy)
					state_d = pool_pkg::ST_DONE;
			end
			pool_pkg::ST_DONE: begin
				state_d = pool_pkg::ST_IDLE;
			end
			default: begin
				state_d = pool_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= pool_pkg::ST_IDLE;
		else
			state <= state_d;
	end

	always_ff @(posedge clk) begin
		if (cmd_accept)
			cmd_q <= i_cmd;
	end

	assign o_cmd = cmd_q;
	assign o_busy = (state == pool_pkg::ST_BUSY) || (state == pool_pkg::ST_DRAIN);
	assign o_done = (state == pool_pkg::ST_DONE); // DONE lasts one cycle before IDLE

	a_last_in_busy: assert property (
		@(posedge clk) disable iff (rst)
		i_cmd_last |-> (state == pool_pkg::ST_BUSY)
	) else $error("pool_ctrl: command end seen outside the busy state");

endmodule

// ==== rtl/pool_engine_top.sv ====
`timescale 1ns/1ps

module pool_engine_top (
	input logic clk,
	input logic rst,
	input logic i_cmd_valid,
	input pool_pkg::pool_cmd_t i_cmd,
	input pool_pkg::word_t i_word,
	output pool_pkg::word_t o_word,
	output logic o_busy,
	output logic o_done
);

	pool_pkg::pool_cmd_t cmd_q; // Latched command
	logic busy;
	logic cmd_last;
	logic ser_busy;
	pool_pkg::atom_strb_t raw_atom; // Valid and data only
	pool_pkg::atom_strb_t flag_atom; // With window flags
	logic result_valid;
	pool_pkg::atom_t result;

	pool_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.i_cmd_valid(i_cmd_valid),
		.i_cmd(i_cmd),
		.i_cmd_last(cmd_last),
		.i_ser_busy(ser_busy),
		.o_cmd(cmd_q),
		.o_busy(busy),
		.o_done(o_done)
	);

	atom_deserializer u_deser (
		.clk(clk),
		.rst(rst),
		.i_busy(busy),
		.i_word(i_word),
		.o_atom(raw_atom)
	);

	window_counter u_win_cnt (
		.clk(clk),
		.rst(rst),
		.i_busy(busy),
		.i_cmd(cmd_q),
		.i_atom(raw_atom),
		.o_atom(flag_atom),
		.o_cmd_last(cmd_last)
	);

	pool_lanes u_lanes (
		.clk(clk),
		.rst(rst),
		.i_cmd(cmd_q),
		.i_atom(flag_atom),
		.o_result_valid(result_valid),
		.o_result(result)
	);

	result_serializer u_ser (
		.clk(clk),
		.rst(rst),
		.i_result_valid(result_valid),
		.i_result(result),
		.o_word(o_word),
		.o_busy(ser_busy)
	);

	assign o_busy = busy;

endmodule

// ==== rtl/pool_lanes.sv ====
`timescale 1ns/1ps

module pool_lanes (
	input logic clk,
	input logic rst,
	input pool_pkg::pool_cmd_t i_cmd,
	input pool_pkg::atom_strb_t i_atom,
	output logic o_result_valid,
	output pool_pkg::atom_t o_result
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_atom.valid && i_atom.last;
	end

	for (genvar g = 0; g < pool_pkg::LANES; g++) begin : g_lane
		logic [pool_pkg::ACC_W-1:0] word_ext;
		logic [pool_pkg::ACC_W-1:0] acc_q;
		logic [pool_pkg::ACC_W-1:0] acc_d;
		logic [pool_pkg::ACC_W-1:0] avg;
		logic [pool_pkg::DATA_W-1:0] res_q;

		assign word_ext = {{(pool_pkg::ACC_W - pool_pkg::DATA_W){1'b0}}, i_atom.atom[g]};

		// Next accumulator value, including the current atom
		always_comb begin
			if (i_atom.first)
				acc_d = word_ext; // First atom of a window restarts the lane
			else if (i_cmd.op == pool_pkg::OP_MAX)
				acc_d = (word_ext > acc_q) ? word_ext : acc_q; // Unsigned compare
			else
				acc_d = acc_q + word_ext;
		end

		assign avg = acc_d >> i_cmd.win_log2; // Rounds down

		always_ff @(posedge clk) begin
			if (i_atom.valid) begin
				acc_q <= acc_d;
				if (i_atom.last) begin
					if (i_cmd.op == pool_pkg::OP_MAX)
						res_q <= acc_d[pool_pkg::DATA_W-1:0];
					else
						res_q <= avg[pool_pkg::DATA_W-1:0];
				end
			end
		end

		assign o_result[g] = res_q;
	end

endmodule

// ==== rtl/pool_pkg.sv ====
package pool_pkg;

	// Datapath geometry
	localparam int DATA_W = 16;
	localparam int LANES = 4;
	localparam int LANE_IDX_W = $clog2(LANES);
	localparam logic [LANE_IDX_W-1:0] LAST_LANE = LANE_IDX_W'(LANES - 1);

	// Window geometry, 1 to 8 atoms per window
	localparam int WIN_LOG2_W = 2;
	localparam int WIN_COUNT_W = 8;
	localparam int ATOM_CNT_W = 2 ** WIN_LOG2_W - 1; // Atom index 0..7 within a window
	localparam int ACC_W = DATA_W + 3; // Sum of 8 words fits without overflow

	typedef enum logic {
		OP_MAX = 1'b0,
		OP_AVG = 1'b1
	} pool_op_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_BUSY = 2'd1,
		ST_DRAIN = 2'd2,
		ST_DONE = 2'd3
	} ctrl_state_e;

	typedef struct packed {
		pool_op_e op;
		logic [WIN_LOG2_W-1:0] win_log2;
		logic [WIN_COUNT_W-1:0] windows; // Windows per command, never zero
	} pool_cmd_t;

	typedef struct packed {
		logic valid;
		logic [DATA_W-1:0] data;
	} word_t;

	typedef logic [LANES-1:0][DATA_W-1:0] atom_t; // Lane 0 in the low word

	typedef struct packed {
		logic valid;
		logic first; // First atom of a window
		logic last; // Last atom of a window
		atom_t atom;
	} atom_strb_t;

endpackage

// ==== rtl/result_serializer.sv ====
`timescale 1ns/1ps

module result_serializer (
	input logic clk,
	input logic rst,
	input logic i_result_valid,
	input pool_pkg::atom_t i_result,
	output pool_pkg::word_t o_word,
	output logic o_busy
);

	logic [pool_pkg::LANE_IDX_W-1:0] remain; // Words still to send after the current one
	pool_pkg::atom_t shift_q;
	logic [pool_pkg::DATA_W-1:0] data_q;
	logic valid_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			remain <= '0;
			valid_q <= 1'b0;
		end else if (i_result_valid) begin
			remain <= pool_pkg::LAST_LANE;
			valid_q <= 1'b1;
		end else if (remain != '0) begin
			remain <= remain - 1'b1;
			valid_q <= 1'b1;
		end else begin
			valid_q <= 1'b0;
		end
	end

	// Lane 0 goes out right after the load, the rest shift down one per cycle
	always_ff @(posedge clk) begin
		if (i_result_valid) begin
			data_q <= i_result[0];
			shift_q <= i_result >> pool_pkg::DATA_W;
		end else if (remain != '0) begin
			data_q <= shift_q[0];
			shift_q <= shift_q >> pool_pkg::DATA_W;
		end
	end

	assign o_word = '{valid: valid_q, data: data_q};

	// Low during the last word so the controller can finish on the next cycle
	assign o_busy = i_result_valid || (remain != '0);

	a_no_load_busy: assert property (
		@(posedge clk) disable iff (rst)
		i_result_valid |-> (remain == '0)
	) else $error("result_serializer: new result while words still pending");

endmodule

// ==== rtl/window_counter.sv ====
`timescale 1ns/1ps

module window_counter (
	input logic clk,
	input logic rst,
	input logic i_busy,
	input pool_pkg::pool_cmd_t i_cmd,
	input pool_pkg::atom_strb_t i_atom,
	output pool_pkg::atom_strb_t o_atom,
	output logic o_cmd_last
);

	logic [pool_pkg::ATOM_CNT_W-1:0] atom_cnt;
	logic [pool_pkg::WIN_COUNT_W-1:0] win_cnt;
	logic at_last;
	logic final_win;

	// Window end when the next count would reach 2**win_log2
	assign at_last = ({1'b0, atom_cnt} + 1'b1) ==
		({{pool_pkg::ATOM_CNT_W{1'b0}}, 1'b1} << i_cmd.win_log2);
	assign final_win = (win_cnt == i_cmd.windows - 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atom_cnt <= '0;
			win_cnt <= '0;
		end else if (!i_busy) begin
			atom_cnt <= '0; // Ready for the next command
			win_cnt <= '0;
		end else if (i_atom.valid) begin
			if (at_last) begin
				atom_cnt <= '0;
				win_cnt <= win_cnt + 1'b1;
			end else begin
				atom_cnt <= atom_cnt + 1'b1;
			end
		end
	end

	// Flags are added in the same cycle as the atom
	always_comb begin
		o_atom = i_atom;
		o_atom.first = (atom_cnt == '0);
		o_atom.last = at_last;
	end

	assign o_cmd_last = i_atom.valid && at_last && final_win;

	a_atom_when_busy: assert property (
		@(posedge clk) disable iff (rst)
		i_atom.valid |-> i_busy
	) else $error("window_counter: atom strobe outside a command");

endmodule

// ==== sim/pool_checker.sv ====
`timescale 1ns/1ps

module pool_checker (
	input logic clk,
	input logic rst,
	input logic i_cmd_valid,
	input pool_pkg::word_t i_dut_word,
	input logic i_dut_busy,
	input logic i_dut_done,
	output int o_value_errors,
	output int o_protocol_errors,
	output int o_extra_words,
	output int o_missing_words
);

	int cmd_words_q[$]; // Result words per command, in file order
	logic [pool_pkg::DATA_W-1:0] exp_q[$];
	int cmd_idx = 0;
	int exp_idx = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	int extra_words = 0;
	int missing_words = 0;
	int words_left = 0;
	logic in_cmd = 1'b0; // Model of the busy window
	logic done_due = 1'b0; // Last word seen, o_done due next cycle

	initial begin : load_expected
		int fd;
		int n;
		string line;
		string tag;
		logic [31:0] a, b, c, d;
		fd = $fopen("sim/pool_vectors.txt", "r");
		if (fd == 0) begin
			$display("checker cannot open sim/pool_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0) begin
					tag = "";
					n = $sscanf(line, "%s %h %h %h %h", tag, a, b, c, d);
					if (tag == "C" && n >= 4) begin
						cmd_words_q.push_back(int'(c[pool_pkg::WIN_COUNT_W-1:0]) * pool_pkg::LANES);
					end else if (tag == "E" && n >= 5) begin
						exp_q.push_back(a[pool_pkg::DATA_W-1:0]); // Lane 0 first
						exp_q.push_back(b[pool_pkg::DATA_W-1:0]);
						exp_q.push_back(c[pool_pkg::DATA_W-1:0]);
						exp_q.push_back(d[pool_pkg::DATA_W-1:0]);
					end
				end
			end
			$fclose(fd);
		end
	end

	// Outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin : compare
		logic accept;
		logic exp_busy;
		if (rst) begin
			if (i_dut_word.valid !== 1'b0 || i_dut_busy !== 1'b0 || i_dut_done !== 1'b0) begin
				$display("error at %0t: outputs not low during reset", $time);
				protocol_errors++;
			end
		end else begin
			accept = i_cmd_valid && !in_cmd; // Strobes during a command are dropped
			exp_busy = in_cmd && !done_due;
			if (i_dut_done !== done_due) begin
				$display("error at %0t: o_done is %b, expected %b", $time, i_dut_done, done_due);
				protocol_errors++;
			end
			if (i_dut_busy !== exp_busy) begin
				$display("error at %0t: o_busy is %b, expected %b", $time, i_dut_busy, exp_busy);
				protocol_errors++;
			end
			if (done_due) begin
				in_cmd = 1'b0;
				done_due = 1'b0;
			end
			if (i_dut_word.valid === 1'b1) begin
				if (!in_cmd || words_left == 0 || exp_idx >= exp_q.size()) begin
					$display("error at %0t: extra result word %h", $time, i_dut_word.data);
					extra_words++;
				end else begin
					if (i_dut_word.data !== exp_q[exp_idx]) begin
						$display("error at %0t: result word %0d is %h, expected %h",
							$time, exp_idx, i_dut_word.data, exp_q[exp_idx]);
						value_errors++;
					end
					exp_idx++;
					words_left--;
					done_due = (words_left == 0);
				end
			end
			if (accept) begin
				in_cmd = 1'b1;
				words_left = (cmd_idx < cmd_words_q.size()) ? cmd_words_q[cmd_idx] : 0;
				cmd_idx++;
			end
		end
		missing_words = exp_q.size() - exp_idx;
	end

	assign o_value_errors = value_errors;
	assign o_protocol_errors = protocol_errors;
	assign o_extra_words = extra_words;
	assign o_missing_words = missing_words;

endmodule

// ==== sim/pool_vectors.txt ====
# C op win_log2 windows gaps | B op win_log2 windows, sent while busy | I word, sent while idle
# W lane0 lane1 lane2 lane3 [repeat] is one input atom | E lane0..lane3 is one result; all hex
I 1234
C 0 2 1 1
B 1 0 1
W 0010 8000 0003 0100
W 0020 7fff 0004 00ff
W 0005 0001 ffff 0100
W 0030 8001 0002 0101
E 0030 8001 ffff 0101
C 1 0 3 0
W 0001 0002 fffe 1234
W 0000 ffff 0007 abcd
W 8000 0011 00ff 4321
E 0001 0002 fffe 1234
E 0000 ffff 0007 abcd
E 8000 0011 00ff 4321
I dead
C 1 1 1 1
W 0003 0010 ffff 0001
W 0004 0011 ffff 0000
E 0003 0010 ffff 0000
C 1 3 1 1
W ffff ffff ffff ffff 8
E ffff ffff ffff ffff

// ==== sim/tb_pool_engine.sv ====
`timescale 1ns/1ps

module tb_pool_engine;

	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic rst;
	logic i_cmd_valid;
	pool_pkg::pool_cmd_t i_cmd;
	pool_pkg::word_t i_word;
	pool_pkg::word_t o_word;
	logic o_busy;
	logic o_done;
	logic cmd_open; // Command sent and its o_done not yet seen
	logic gaps_on; // Random idle cycles between words of this command
	int run_errors;
	int value_errors;
	int protocol_errors;
	int extra_words;
	int missing_words;

	pool_engine_top dut (
		.clk(clk),
		.rst(rst),
		.i_cmd_valid(i_cmd_valid),
		.i_cmd(i_cmd),
		.i_word(i_word),
		.o_word(o_word),
		.o_busy(o_busy),
		.o_done(o_done)
	);

	pool_checker u_checker (
		.clk(clk),
		.rst(rst),
		.i_cmd_valid(i_cmd_valid),
		.i_dut_word(o_word),
		.i_dut_busy(o_busy),
		.i_dut_done(o_done),
		.o_value_errors(value_errors),
		.o_protocol_errors(protocol_errors),
		.o_extra_words(extra_words),
		.o_missing_words(missing_words)
	);

	always #50 clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_cmd(input logic [31:0] op, input logic [31:0] win_log2,
		input logic [31:0] windows);
		i_cmd_valid = 1'b1;
		i_cmd.op = op[0] ? pool_pkg::OP_AVG : pool_pkg::OP_MAX;
		i_cmd.win_log2 = win_log2[pool_pkg::WIN_LOG2_W-1:0];
		i_cmd.windows = windows[pool_pkg::WIN_COUNT_W-1:0];
		next_cycle();
		i_cmd_valid = 1'b0;
	endtask

	task automatic send_word(input logic [pool_pkg::DATA_W-1:0] data, input logic with_gap);
		int gap;
		gap = with_gap ? int'($urandom % 4) : 0;
		repeat (gap) next_cycle();
		i_word.valid = 1'b1;
		i_word.data = data;
		next_cycle();
		i_word.valid = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (o_done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			next_cycle();
			cycles++;
		end
		if (o_done !== 1'b1) begin
			$display("timeout: o_done did not pulse within %0d cycles", TIMEOUT_CYCLES);
			run_errors++;
		end else begin
			next_cycle(); // Back in idle
		end
		cmd_open = 1'b0;
	endtask

	task automatic apply_line(input string line);
		string tag;
		logic [31:0] a, b, c, d, e;
		int n;
		int reps;
		tag = "";
		n = $sscanf(line, "%s %h %h %h %h %h", tag, a, b, c, d, e);
		reps = (n >= 6) ? int'(e) : 1;
		if (tag == "C") begin
			if (cmd_open)
				wait_done();
			if (run_errors == 0) begin
				gaps_on = d[0];
				send_cmd(a, b, c);
				cmd_open = 1'b1;
			end
		end else if (tag == "B") begin
			send_cmd(a, b, c); // Lands while busy
		end else if (tag == "W") begin
			repeat (reps) begin
				send_word(a[pool_pkg::DATA_W-1:0], gaps_on);
				send_word(b[pool_pkg::DATA_W-1:0], gaps_on);
				send_word(c[pool_pkg::DATA_W-1:0], gaps_on);
				send_word(d[pool_pkg::DATA_W-1:0], gaps_on);
			end
		end else if (tag == "I") begin
			if (cmd_open)
				wait_done();
			send_word(a[pool_pkg::DATA_W-1:0], 1'b0);
		end
	endtask

	initial begin : run
		int fd;
		int total;
		string line;
		clk = 1'b0;
		rst = 1'b1;
		i_cmd_valid = 1'b0;
		i_cmd = '0;
		i_word = '0;
		cmd_open = 1'b0;
		gaps_on = 1'b0;
		run_errors = 0;
		void'($urandom(32'h4abc_dda8));
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (4) next_cycle(); // Quiet outputs before the first command
		fd = $fopen("sim/pool_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/pool_vectors.txt");
			run_errors++;
		end else begin
			while (!$feof(fd) && run_errors == 0) begin
				if ($fgets(line, fd) > 0)
					apply_line(line);
			end
			$fclose(fd);
			if (cmd_open && run_errors == 0)
				wait_done();
		end
		repeat (8) next_cycle(); // Catch stray words after the last command
		total = value_errors + protocol_errors + extra_words + missing_words + run_errors;
		$display("errors: %0d value, %0d protocol, %0d extra word, %0d missing word, %0d run",
			value_errors, protocol_errors, extra_words, missing_words, run_errors);
		if (total == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
